//--- Bender.yml
package:
  name: datapath

sources:
  - isaPkg.sv
  - pipePkg.sv
  - pipeIfs.sv
  - fetchUnit.sv
  - mainDecoder.sv
  - decodeStage.sv
  - hazardUnit.sv
  - executeStage.sv
  - memoryStage.sv
  - datapath.sv
  - target: simulation
    files:
      - tbDatapath.sv

//--- datapath.sv
module datapath (
    input  logic              clk,
    input  logic              rst,
    input  pipePkg::word_t    instr,
    input  pipePkg::word_t    memRdata,
    output pipePkg::word_t    pcNext,
    output pipePkg::word_t    memAddrE,
    output logic              memWriteEn,
    output pipePkg::word_t    memAddr,
    output pipePkg::word_t    memWdata,
    output pipePkg::word_t    debugWbPc,
    output logic              debugWbRfWen,
    output pipePkg::regAddr_t debugWbRfWnum,
    output pipePkg::word_t    debugWbRfWdata
);
    import pipePkg::*;
    import isaPkg::*;

    word_t    pcD, instrD, branchTarget, memForward;
    regAddr_t rsD, rtD;
    logic     stall, squash, branchTaken;
    fwdSel_t  fwdA, fwdB;

    idExIf  idExBus ();
    exMemIf exMemBus ();
    memWbIf memWbBus ();

    assign rsD = instrD[rsMsb -: $bits(regAddr_t)];   // for load-use check
    assign rtD = instrD[rtMsb -: $bits(regAddr_t)];

    fetchUnit fetch (
        .clk(clk), .rst(rst), .stall(stall), .squash(squash), .branchTaken(branchTaken),
        .branchTarget(branchTarget), .instr(instr), .pcNext(pcNext), .pcD(pcD),
        .instrD(instrD)
    );

    decodeStage decode (
        .clk(clk), .rst(rst), .stall(stall), .pcD(pcD), .instrD(instrD),
        .wb(memWbBus), .idEx(idExBus)
    );

    hazardUnit hazard (
        .idEx(idExBus), .exMem(exMemBus), .wb(memWbBus), .rsD(rsD), .rtD(rtD),
        .branchTaken(branchTaken), .stall(stall), .squash(squash), .fwdA(fwdA), .fwdB(fwdB)
    );

    executeStage execute (
        .clk(clk), .rst(rst), .idEx(idExBus), .wb(memWbBus), .fwdA(fwdA), .fwdB(fwdB),
        .memForward(memForward), .exMem(exMemBus), .branchTaken(branchTaken),
        .branchTarget(branchTarget), .memAddrE(memAddrE)
    );

    memoryStage memory (
        .clk(clk), .rst(rst), .exMem(exMemBus), .memRdata(memRdata),
        .memForward(memForward), .memWriteEn(memWriteEn), .memAddr(memAddr),
        .memWdata(memWdata), .wb(memWbBus)
    );

    // trace of retiring register writes
    assign debugWbPc      = memWbBus.pc;
    assign debugWbRfWen   = memWbBus.regWrite && (memWbBus.dest != regZero);
    assign debugWbRfWnum  = memWbBus.dest;
    assign debugWbRfWdata = memWbBus.result;
endmodule

//--- decodeStage.sv
module decodeStage (
    input  logic           clk,
    input  logic           rst,
    input  logic           stall,
    input  pipePkg::word_t pcD,
    input  pipePkg::word_t instrD,
    memWbIf.consumer       wb,
    idExIf.producer        idEx
);
    import pipePkg::*;
    import isaPkg::*;

    word_t    regFile [32];
    regAddr_t rs, rt, rd;
    word_t    rsVal, rtVal, imm;
    aluOp_t   aluOp;
    logic     useImm, signExt, regWrite, destIsRt;
    logic     memRead, memWrite, isBeq, isBne;

    mainDecoder decoder (
        .instr(instrD), .aluOp(aluOp), .useImm(useImm), .signExt(signExt),
        .regWrite(regWrite), .destIsRt(destIsRt), .memRead(memRead),
        .memWrite(memWrite), .isBeq(isBeq), .isBne(isBne)
    );

    assign rs  = instrD[rsMsb -: $bits(regAddr_t)];
    assign rt  = instrD[rtMsb -: $bits(regAddr_t)];
    assign rd  = instrD[rdMsb -: $bits(regAddr_t)];
    assign imm = {{($bits(word_t)-immWidth){signExt & instrD[immWidth-1]}},
                  instrD[immWidth-1:0]};

    always_ff @(posedge clk) begin
        if (rst)
            regFile[regZero] <= '0;   // r0 hardwired to zero
        else if (wb.regWrite && wb.dest != regZero)
            regFile[wb.dest] <= wb.result;
    end

    // write-through from write-back
    assign rsVal = (wb.regWrite && wb.dest == rs && rs != regZero) ? wb.result : regFile[rs];
    assign rtVal = (wb.regWrite && wb.dest == rt && rt != regZero) ? wb.result : regFile[rt];

    always_ff @(posedge clk) begin
        if (rst || stall) begin
            idEx.regWrite <= 1'b0;   // bubble
            idEx.memRead  <= 1'b0;
            idEx.memWrite <= 1'b0;
            idEx.isBeq    <= 1'b0;
            idEx.isBne    <= 1'b0;
        end else begin
            idEx.regWrite <= regWrite;
            idEx.memRead  <= memRead;
            idEx.memWrite <= memWrite;
            idEx.isBeq    <= isBeq;
            idEx.isBne    <= isBne;
        end
    end

    always_ff @(posedge clk) begin
        idEx.pc     <= pcD;
        idEx.rsVal  <= rsVal;
        idEx.rtVal  <= rtVal;
        idEx.imm    <= imm;
        idEx.rs     <= rs;
        idEx.rt     <= rt;
        idEx.dest   <= destIsRt ? rt : rd;
        idEx.aluOp  <= aluOp;
        idEx.useImm <= useImm;
    end

    // r0 reaches execute as zero, even with a pending write to it
    zeroRegRead: assert property (@(posedge clk) disable iff (rst)
        (idEx.rs != regZero || idEx.rsVal == '0) && (idEx.rt != regZero || idEx.rtVal == '0));
endmodule

//--- executeStage.sv
module executeStage (
    input  logic             clk,
    input  logic             rst,
    idExIf.consumer          idEx,
    memWbIf.consumer         wb,
    input  pipePkg::fwdSel_t fwdA,
    input  pipePkg::fwdSel_t fwdB,
    input  pipePkg::word_t   memForward,
    exMemIf.producer         exMem,
    output logic             branchTaken,
    output pipePkg::word_t   branchTarget,
    output pipePkg::word_t   memAddrE
);
    import pipePkg::*;
    import isaPkg::*;

    word_t srcA, rtFwd, srcB, aluOut;

    function automatic word_t forwarded(fwdSel_t sel, word_t regVal, word_t memVal,
                                        word_t wbVal);
        case (sel)
            fwdMem:  return memVal;
            fwdWb:   return wbVal;
            default: return regVal;
        endcase
    endfunction

    assign srcA  = forwarded(fwdA, idEx.rsVal, memForward, wb.result);
    assign rtFwd = forwarded(fwdB, idEx.rtVal, memForward, wb.result);
    assign srcB  = idEx.useImm ? idEx.imm : rtFwd;

    always_comb begin
        case (idEx.aluOp)
            aluAdd:  aluOut = srcA + srcB;
            aluSub:  aluOut = srcA - srcB;
            aluAnd:  aluOut = srcA & srcB;
            aluOr:   aluOut = srcA | srcB;
            aluXor:  aluOut = srcA ^ srcB;
            aluSlt:  aluOut = word_t'($signed(srcA) < $signed(srcB));
            aluSltu: aluOut = word_t'(srcA < srcB);
            aluLui:  aluOut = {srcB[immWidth-1:0], {immWidth{1'b0}}};
            default: aluOut = '0;
        endcase
    end

    assign branchTaken  = (idEx.isBeq && srcA == rtFwd) || (idEx.isBne && srcA != rtFwd);
    assign branchTarget = idEx.pc + 32'd4 + {idEx.imm[29:0], 2'b00};
    assign memAddrE     = aluOut;   // data memory reads this at the edge

    always_ff @(posedge clk) begin
        if (rst) begin
            exMem.regWrite <= 1'b0;
            exMem.memRead  <= 1'b0;
            exMem.memWrite <= 1'b0;
        end else begin
            exMem.regWrite <= idEx.regWrite;
            exMem.memRead  <= idEx.memRead;
            exMem.memWrite <= idEx.memWrite;
        end
    end

    always_ff @(posedge clk) begin
        exMem.pc        <= idEx.pc;
        exMem.aluOut    <= aluOut;
        exMem.storeData <= rtFwd;
        exMem.dest      <= idEx.dest;
    end
endmodule

//--- fetchUnit.sv
module fetchUnit (
    input  logic           clk,
    input  logic           rst,
    input  logic           stall,
    input  logic           squash,
    input  logic           branchTaken,
    input  pipePkg::word_t branchTarget,
    input  pipePkg::word_t instr,
    output pipePkg::word_t pcNext,
    output pipePkg::word_t pcD,
    output pipePkg::word_t instrD
);
    import pipePkg::*;

    word_t pcF;
    logic  fetchLive;   // instr lines up with pcF

    always_comb begin
        if (stall)
            pcNext = pcF;   // load-use, refetch same word
        else if (branchTaken)
            pcNext = branchTarget;
        else
            pcNext = pcF + 32'd4;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pcF       <= pcReset - 32'd4;   // so pcNext starts at pcReset
            fetchLive <= 1'b0;
        end else begin
            pcF       <= pcNext;
            fetchLive <= 1'b1;
        end
    end

    // fetch/decode register, all-zero word is a nop
    always_ff @(posedge clk) begin
        if (rst)
            instrD <= '0;
        else if (!stall)
            instrD <= (squash || !fetchLive) ? word_t'(0) : instr;
    end

    always_ff @(posedge clk) begin
        if (!stall)
            pcD <= pcF;
    end
endmodule

//--- hazardUnit.sv
module hazardUnit (
    idExIf.monitor             idEx,
    exMemIf.monitor            exMem,
    memWbIf.monitor            wb,
    input  pipePkg::regAddr_t  rsD,
    input  pipePkg::regAddr_t  rtD,
    input  logic               branchTaken,
    output logic               stall,
    output logic               squash,
    output pipePkg::fwdSel_t   fwdA,
    output pipePkg::fwdSel_t   fwdB
);
    import pipePkg::*;

    function automatic fwdSel_t pickSource(regAddr_t src, regAddr_t memDest, logic memWr,
                                           regAddr_t wbDest, logic wbWr);
        fwdSel_t sel;
        sel = fwdReg;
        if (src != regZero && wbWr && wbDest == src)
            sel = fwdWb;
        if (src != regZero && memWr && memDest == src)
            sel = fwdMem;   // younger result wins
        return sel;
    endfunction

    assign fwdA = pickSource(idEx.rs, exMem.dest, exMem.regWrite, wb.dest, wb.regWrite);
    assign fwdB = pickSource(idEx.rt, exMem.dest, exMem.regWrite, wb.dest, wb.regWrite);

    // load in execute feeding the instruction in decode
    assign stall = idEx.memRead && idEx.dest != regZero
                   && (idEx.dest == rsD || idEx.dest == rtD);

    assign squash = branchTaken;   // kill the word fetched after the delay slot

    stallSquashExclusive: assert final (stall !== 1'b1 || squash !== 1'b1);
endmodule

//--- isaPkg.sv
package isaPkg;

    typedef logic [5:0] opcode_t;
    typedef logic [5:0] funct_t;

    // major opcodes, instr[31:26]
    localparam opcode_t opSpecial = 6'h00;
    localparam opcode_t opBeq     = 6'h04;
    localparam opcode_t opBne     = 6'h05;
    localparam opcode_t opAddiu   = 6'h09;
    localparam opcode_t opAndi    = 6'h0c;
    localparam opcode_t opOri     = 6'h0d;
    localparam opcode_t opLui     = 6'h0f;
    localparam opcode_t opLw      = 6'h23;
    localparam opcode_t opSw      = 6'h2b;

    // SPECIAL function field
    localparam funct_t fnAddu = 6'h21;
    localparam funct_t fnSubu = 6'h23;
    localparam funct_t fnAnd  = 6'h24;
    localparam funct_t fnOr   = 6'h25;
    localparam funct_t fnXor  = 6'h26;
    localparam funct_t fnSlt  = 6'h2a;
    localparam funct_t fnSltu = 6'h2b;

    localparam int rsMsb    = 25;
    localparam int rtMsb    = 20;
    localparam int rdMsb    = 15;
    localparam int immWidth = 16;

    typedef enum logic [2:0] {
        aluAdd, aluSub, aluAnd, aluOr, aluXor, aluSlt, aluSltu, aluLui
    } aluOp_t;

endpackage

//--- mainDecoder.sv
module mainDecoder (
    input  pipePkg::word_t instr,
    output isaPkg::aluOp_t aluOp,
    output logic           useImm,
    output logic           signExt,
    output logic           regWrite,
    output logic           destIsRt,
    output logic           memRead,
    output logic           memWrite,
    output logic           isBeq,
    output logic           isBne
);
    import isaPkg::*;

    opcode_t opcode;
    funct_t  funct;

    assign opcode = instr[$bits(instr)-1 -: $bits(opcode_t)];
    assign funct  = instr[$bits(funct_t)-1:0];

    always_comb begin
        aluOp    = aluAdd;
        useImm   = 1'b0;
        signExt  = 1'b0;
        regWrite = 1'b0;
        destIsRt = 1'b0;
        memRead  = 1'b0;
        memWrite = 1'b0;
        isBeq    = 1'b0;
        isBne    = 1'b0;
        case (opcode)
            opSpecial: begin
                regWrite = 1'b1;
                case (funct)
                    fnAddu:  aluOp = aluAdd;
                    fnSubu:  aluOp = aluSub;
                    fnAnd:   aluOp = aluAnd;
                    fnOr:    aluOp = aluOr;
                    fnXor:   aluOp = aluXor;
                    fnSlt:   aluOp = aluSlt;
                    fnSltu:  aluOp = aluSltu;
                    default: regWrite = 1'b0;   // shifts, jr etc. fall to nop
                endcase
            end
            opAddiu, opLw, opSw: begin
                useImm   = 1'b1;
                signExt  = 1'b1;
                destIsRt = 1'b1;
                regWrite = (opcode != opSw);
                memRead  = (opcode == opLw);
                memWrite = (opcode == opSw);
            end
            opAndi, opOri, opLui: begin
                useImm   = 1'b1;    // zero extended
                destIsRt = 1'b1;
                regWrite = 1'b1;
                aluOp    = (opcode == opAndi) ? aluAnd : (opcode == opOri) ? aluOr : aluLui;
            end
            opBeq, opBne: begin
                signExt = 1'b1;     // offset for the target
                aluOp   = aluSub;
                isBeq   = (opcode == opBeq);
                isBne   = (opcode == opBne);
            end
            default: ;
        endcase
    end
endmodule

//--- memoryStage.sv
module memoryStage (
    input  logic           clk,
    input  logic           rst,
    exMemIf.consumer       exMem,
    input  pipePkg::word_t memRdata,
    output pipePkg::word_t memForward,
    output logic           memWriteEn,
    output pipePkg::word_t memAddr,
    output pipePkg::word_t memWdata,
    memWbIf.producer       wb
);

    assign memWriteEn = exMem.memWrite;
    assign memAddr    = exMem.aluOut;
    assign memWdata   = exMem.storeData;

    // result of this stage, also the bypass value for execute
    assign memForward = exMem.memRead ? memRdata : exMem.aluOut;

    always_ff @(posedge clk) begin
        if (rst)
            wb.regWrite <= 1'b0;
        else
            wb.regWrite <= exMem.regWrite;
    end

    always_ff @(posedge clk) begin
        wb.pc     <= exMem.pc;
        wb.dest   <= exMem.dest;
        wb.result <= memForward;
    end

    // a store never loads and never retires a register write
    storeNotLoad: assert property (@(posedge clk) disable iff (rst)
        exMem.memWrite |-> !exMem.memRead ##1 !wb.regWrite);
endmodule

//--- pipeIfs.sv
interface idExIf;
    import pipePkg::*;
    import isaPkg::*;

    word_t    pc;
    word_t    rsVal;
    word_t    rtVal;
    word_t    imm;
    regAddr_t rs;
    regAddr_t rt;
    regAddr_t dest;
    aluOp_t   aluOp;
    logic     useImm;
    logic     regWrite;
    logic     memRead;
    logic     memWrite;
    logic     isBeq;
    logic     isBne;

    modport producer (output pc, rsVal, rtVal, imm, rs, rt, dest, aluOp, useImm,
                      regWrite, memRead, memWrite, isBeq, isBne);
    modport consumer (input pc, rsVal, rtVal, imm, rs, rt, dest, aluOp, useImm,
                      regWrite, memRead, memWrite, isBeq, isBne);
    modport monitor (input rs, rt, dest, memRead);
endinterface

interface exMemIf;
    import pipePkg::*;

    word_t    pc;
    word_t    aluOut;
    word_t    storeData;
    regAddr_t dest;
    logic     regWrite;
    logic     memRead;
    logic     memWrite;

    modport producer (output pc, aluOut, storeData, dest, regWrite, memRead, memWrite);
    modport consumer (input pc, aluOut, storeData, dest, regWrite, memRead, memWrite);
    modport monitor (input dest, regWrite);
endinterface

interface memWbIf;
    import pipePkg::*;

    word_t    pc;
    regAddr_t dest;
    logic     regWrite;
    word_t    result;

    modport producer (output pc, dest, regWrite, result);
    modport consumer (input pc, dest, regWrite, result);
    modport monitor (input dest, regWrite);
endinterface

//--- pipePkg.sv
package pipePkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  regAddr_t;

    // first fetch address after reset
    localparam word_t pcReset = 32'hbfc00000;

    localparam regAddr_t regZero = 5'd0;

    // operand source for execute
    typedef enum logic [1:0] {
        fwdReg,
        fwdMem,
        fwdWb
    } fwdSel_t;

endpackage

//--- pipelineTests.txt
# I <instruction hex>, W <register hex> <value hex>, S <address hex> <value hex>
# W and S lines give the expected write-backs and stores in program order
I 24010005   # addiu r1, r0, 5
W 01 00000005
I 2402ffff   # addiu r2, r0, -1
W 02 ffffffff
I 00221821   # addu r3, r1, r2
W 03 00000004
I 00612023   # subu r4, r3, r1
W 04 ffffffff
I 0041282a   # slt r5, r2, r1
W 05 00000001
I 0041302b   # sltu r6, r2, r1
W 06 00000000
I 3c078000   # lui r7, 0x8000
W 07 80000000
I 00e1402a   # slt r8, r7, r1
W 08 00000001
I 34e91234   # ori r9, r7, 0x1234
W 09 80001234
I 304a8f0f   # andi r10, r2, 0x8f0f
W 0a 00008f0f
I 012a5826   # xor r11, r9, r10
W 0b 80009d3b
I 01696024   # and r12, r11, r9
W 0c 80001030
I 01816825   # or r13, r12, r1
W 0d 80001035
I ac0d0010   # sw r13, 16(r0)
S 00000010 80001035
I 8c0e0010   # lw r14, 16(r0)
W 0e 80001035
I 01c17821   # addu r15, r14, r1 after load-use stall
W 0f 8000103a
I 10210002   # beq r1, r1, +2 taken
I 24100011   # addiu r16, r0, 0x11 delay slot
W 10 00000011
I 24110022   # addiu r17, r0, 0x22 skipped
I 16000002   # bne r16, r0, +2 taken
I 24110033   # addiu r17, r0, 0x33 delay slot
W 11 00000033
I 24120044   # addiu r18, r0, 0x44 skipped
I 12000005   # beq r16, r0, +5 not taken
I 14210005   # bne r1, r1, +5 not taken
I 24120055   # addiu r18, r0, 0x55
W 12 00000055
I 24000077   # addiu r0, r0, 0x77 no write-back
I fc13abcd   # unknown opcode
I 00139880   # sll r19, r19, 2 decodes as nop
I ac120024   # sw r18, 0x24(r0)
S 00000024 00000055
I 24130099   # addiu r19, r0, 0x99
W 13 00000099

//--- tbDatapath.sv
module tbDatapath;
    import pipePkg::*;

    localparam int imemWords    = 64;
    localparam int dmemWords    = 256;
    localparam int eventTimeout = 200;

    logic     clk;
    logic     rst;
    word_t    instr, memRdata;
    word_t    pcNext, memAddrE, memAddr, memWdata;
    word_t    debugWbPc, debugWbRfWdata;
    logic     memWriteEn, debugWbRfWen;
    regAddr_t debugWbRfWnum;

    word_t    imem [imemWords];
    word_t    dmem [dmemWords];
    regAddr_t expWbReg [$];
    word_t    expWbVal [$];
    word_t    expWbPc [$];
    word_t    expStAddr [$];
    word_t    expStVal [$];
    int       wbIdx, stIdx;
    int       wbErrors, storeErrors, otherErrors;

    datapath DUT (
        .clk(clk), .rst(rst), .instr(instr), .memRdata(memRdata), .pcNext(pcNext),
        .memAddrE(memAddrE), .memWriteEn(memWriteEn), .memAddr(memAddr),
        .memWdata(memWdata), .debugWbPc(debugWbPc), .debugWbRfWen(debugWbRfWen),
        .debugWbRfWnum(debugWbRfWnum), .debugWbRfWdata(debugWbRfWdata)
    );

    always #4 clk = ~clk;

    // scrambled from the full address
    function automatic word_t fillWord(word_t addr);
        return ~addr ^ {addr[15:0], addr[31:16]};
    endfunction

    function automatic word_t fetchWord(word_t addr);
        word_t offset;
        offset = addr - pcReset;
        if (offset[1:0] == 2'b00 && offset < imemWords * 4)
            return imem[offset[31:2]];
        return '0;   // nop outside the program
    endfunction

    function automatic word_t loadWord(word_t addr);
        if (addr < dmemWords * 4)
            return dmem[addr[31:2]];
        return fillWord(addr);
    endfunction

    // both memories answer one edge after the address
    always @(posedge clk) begin
        instr <= fetchWord(pcNext);
        if (memWriteEn === 1'b1 && memAddr == memAddrE)
            memRdata <= memWdata;   // store in memory, load in execute
        else
            memRdata <= loadWord(memAddrE);
        if (memWriteEn === 1'b1 && memAddr < dmemWords * 4)
            dmem[memAddr[31:2]] <= memWdata;
    end

    task automatic checkWb(regAddr_t num, word_t data, word_t pc);
        if (num !== expWbReg[wbIdx]) begin
            $display("Error at time %0t: debugWbRfWnum is %0d, expected %0d",
                     $time, num, expWbReg[wbIdx]);
            wbErrors++;
        end
        if (data !== expWbVal[wbIdx]) begin
            $display("Error at time %0t: debugWbRfWdata is %h, expected %h",
                     $time, data, expWbVal[wbIdx]);
            wbErrors++;
        end
        if (pc !== expWbPc[wbIdx]) begin
            $display("Error at time %0t: debugWbPc is %h, expected %h",
                     $time, pc, expWbPc[wbIdx]);
            wbErrors++;
        end
        wbIdx++;
    endtask

    task automatic checkStore(word_t addr, word_t data);
        if (addr !== expStAddr[stIdx]) begin
            $display("Error at time %0t: memAddr is %h, expected %h",
                     $time, addr, expStAddr[stIdx]);
            storeErrors++;
        end
        if (data !== expStVal[stIdx]) begin
            $display("Error at time %0t: memWdata is %h, expected %h",
                     $time, data, expStVal[stIdx]);
            storeErrors++;
        end
        stIdx++;
    endtask

    // outputs settle between edges
    always @(negedge clk) begin
        if (rst === 1'b0 && debugWbRfWen === 1'b1) begin
            if (wbIdx < expWbReg.size()) begin
                checkWb(debugWbRfWnum, debugWbRfWdata, debugWbPc);
            end else begin
                $display("Unexpected register write to r%0d at time %0t", debugWbRfWnum, $time);
                otherErrors++;
            end
        end
        if (rst === 1'b0 && memWriteEn === 1'b1) begin
            if (stIdx < expStVal.size()) begin
                checkStore(memAddr, memWdata);
            end else begin
                $display("Unexpected store to %h at time %0t", memAddr, $time);
                otherErrors++;
            end
        end
    end

    task automatic loadTests();
        int               fd, n, count;
        logic [8*160-1:0] lineBuf;
        logic [7:0]       tag;
        word_t            a, b;
        count = 0;
        fd = $fopen("pipelineTests.txt", "r");
        if (fd == 0) begin
            $display("Could not open pipelineTests.txt");
            otherErrors++;
        end else begin
            while (!$feof(fd)) begin
                lineBuf = '0;
                tag = '0;
                if ($fgets(lineBuf, fd) > 0) begin
                    n = $sscanf(lineBuf, "%s %h %h", tag, a, b);
                    if (n >= 2 && tag == "I") begin
                        if (count < imemWords) begin
                            imem[count] = a;
                        end else begin
                            $display("Program longer than %0d instruction words", imemWords);
                            otherErrors++;
                        end
                        count++;
                    end else if (n == 3 && tag == "W") begin
                        expWbReg.push_back(regAddr_t'(a[4:0]));
                        expWbVal.push_back(b);
                        expWbPc.push_back(pcReset + word_t'((count - 1) * 4));   // last I line
                    end else if (n == 3 && tag == "S") begin
                        expStAddr.push_back(a);
                        expStVal.push_back(b);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic awaitAll(bit stores, int total);
        int last, waited;
        while ((stores ? stIdx : wbIdx) < total) begin
            last = stores ? stIdx : wbIdx;
            waited = 0;
            while ((stores ? stIdx : wbIdx) == last && waited < eventTimeout) begin
                @(posedge clk);
                waited++;
            end
            if ((stores ? stIdx : wbIdx) == last) begin
                $display("Timeout: %s %0d of %0d did not happen within %0d cycles",
                         stores ? "store" : "write-back", last + 1, total, eventTimeout);
                otherErrors++;
                break;
            end
        end
    endtask

    initial begin
        rst = 1'b1;
        clk = 1'b0;
        instr = '0;
        memRdata = '0;
        wbIdx = 0;
        stIdx = 0;
        wbErrors = 0;
        storeErrors = 0;
        otherErrors = 0;
        for (int i = 0; i < imemWords; i++)
            imem[i] = '0;
        for (int i = 0; i < dmemWords; i++)
            dmem[i] = fillWord(word_t'(i * 4));
        loadTests();
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        awaitAll(1'b0, expWbReg.size());
        awaitAll(1'b1, expStVal.size());
        repeat (20) @(posedge clk);   // room for stray write-backs
        $display("write-back errors %0d, store errors %0d, other errors %0d",
                 wbErrors, storeErrors, otherErrors);
        if (wbErrors + storeErrors + otherErrors == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end
endmodule

//--- vlog.f
isaPkg.sv
pipePkg.sv
pipeIfs.sv
fetchUnit.sv
mainDecoder.sv
decodeStage.sv
hazardUnit.sv
executeStage.sv
memoryStage.sv
datapath.sv
tbDatapath.sv
